// ==== ramtest_top.f ====
verilog/ramtest_pkg.sv
verilog/addr_data_gen.sv
verilog/ram_test_gen.sv
verilog/dual_port_ram.sv
verilog/ramtest_top.sv
verif/ramtest_properties.sv
verif/ramtest_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# builds ramtest_tb with Verilator, runs it into sim.log and checks the log

cd "$(dirname "$0")" || exit 1

log=sim.log

verilator --binary --timing --assert -Wno-fatal --top-module ramtest_tb \
  -Mdir obj_dir -f ramtest_top.f
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

./obj_dir/Vramtest_tb > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "Something failed" "$log"; then
  echo "simulation reported a failure"
  exit 1
fi
if ! grep -q "Everything OK" "$log"; then
  echo "simulation ended without a result"
  exit 1
fi
echo "simulation passed"
exit 0

// ==== verif/ramtest_tb.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// runs ramtest_top with addr_bits 12, len_bits 8 and ram_latency 3
// expected sequence is rebuilt from the package seeds and lfsr_taps
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module ramtest_tb;

  localparam int addr_bits = 12;
  localparam int len_bits = 8;
  localparam int ram_latency = 3;
  localparam int end_count = 2 ** len_bits - 1;
  localparam int seq_len = 2 ** len_bits;
  // phase of each timer plus one
  localparam int data_first_stb = 8;
  localparam int inst_first_stb = 20;
  localparam int num_rows = 3;

  logic                  clk;
  logic                  rst;
  logic                  test_ended;
  logic                  test_error;
  ramtest_pkg::mem_req_t inst_req;
  ramtest_pkg::mem_rsp_t inst_rsp;
  ramtest_pkg::mem_req_t data_req;
  ramtest_pkg::mem_rsp_t data_rsp;
  logic [5:0]            flags;

  // name, data transactions to watch, test_ended expected, reset cycles
  string row_name [num_rows] = '{"first_burst", "mid_reset", "full_run"};
  int    row_trans [num_rows] = '{8, 40, end_count};
  bit    row_end [num_rows] = '{1'b0, 1'b0, 1'b1};
  int    row_rst [num_rows] = '{4, 7, 4};

  ramtest_pkg::bus_addr_t seq_addr [seq_len];
  ramtest_pkg::data_t     seq_data [seq_len];

  string test_name = "init";
  int    errors = 0;
  int    checked = 0;
  int    cycles = 0;
  int    cycle_limit = 0;
  int    wr_pos = 0;
  int    rd_pos = 0;
  int    ir_pos = 0;
  int    done_count = 0;
  int    since_rst = -1;
  bit    rst_prev = 1'b1;
  bit    data_stb_prev = 1'b0;
  bit    inst_stb_prev = 1'b0;
  bit    data_seen = 1'b0;
  bit    inst_seen = 1'b0;

  ramtest_top #(
    .addr_bits  (addr_bits),
    .len_bits   (len_bits),
    .ram_latency(ram_latency)
  ) DUT (
    .clk       (clk),
    .rst       (rst),
    .test_ended(test_ended),
    .test_error(test_error),
    .inst_req  (inst_req),
    .inst_rsp  (inst_rsp),
    .data_req  (data_req),
    .data_rsp  (data_rsp)
  );

  assign flags = {inst_req.stb, data_req.stb, inst_rsp.ack, data_rsp.ack, test_ended,
                  test_error};

  initial clk = 1'b0;
  always #2 clk = ~clk;

  function automatic logic [31:0] galois32(input logic [31:0] v);
    logic [31:0] s;
    s = v >> 1;
    if (v[0]) begin
      s = s ^ ramtest_pkg::data_poly;
    end
    return s;
  endfunction

  task automatic build_sequence();
    logic [addr_bits-1:0] a;
    logic [addr_bits-1:0] taps;
    logic [31:0]          hi;
    logic [31:0]          lo;
    taps = addr_bits'(ramtest_pkg::lfsr_taps(addr_bits));
    a = addr_bits'(ramtest_pkg::addr_seed);
    hi = ramtest_pkg::data_seed_hi;
    lo = ramtest_pkg::data_seed_lo;
    for (int i = 0; i < seq_len; i++) begin
      seq_addr[i] = ramtest_pkg::bus_addr_t'(a);
      seq_data[i] = {hi, lo};
      a = a[0] ? ((a >> 1) ^ taps) : (a >> 1);
      hi = galois32(hi);
      lo = galois32(lo);
    end
  endtask

  task automatic report_mismatch(input string what, input logic [63:0] exp,
                                 input logic [63:0] act);
    errors++;
    $display("ERROR %s %s expected %h actual %h", test_name, what, exp, act);
  endtask

  task automatic report_fault(input string msg);
    errors++;
    $display("%s: %s", test_name, msg);
  endtask

  task automatic check_inst_ack();
    checked++;
    // instruction side is read-only
    if (inst_req.we != 1'b0) begin
      report_mismatch("inst we", 64'd0, 64'(inst_req.we));
    end
    if (inst_req.wdata != '0) begin
      report_mismatch("inst wdata", 64'd0, inst_req.wdata);
    end
    if (ir_pos >= seq_len) begin
      report_fault("instruction reads ran past the model sequence");
    end else begin
      if (ir_pos >= wr_pos) begin
        report_fault("instruction reader overtook the writer");
      end
      if (inst_req.addr != seq_addr[ir_pos]) begin
        report_mismatch("inst addr", 64'(seq_addr[ir_pos]), 64'(inst_req.addr));
      end
      if (inst_rsp.rdata != seq_data[ir_pos]) begin
        report_mismatch("inst rdata", seq_data[ir_pos], inst_rsp.rdata);
      end
    end
    ir_pos++;
  endtask

  task automatic check_data_ack();
    logic exp_we;
    exp_we = (done_count % 4) != 3;
    checked++;
    if (data_req.we != exp_we) begin
      report_mismatch("data we", 64'(exp_we), 64'(data_req.we));
    end
    if (wr_pos >= seq_len || rd_pos >= seq_len) begin
      report_fault("data transactions ran past the model sequence");
    end else if (exp_we) begin
      // first write after any reset carries the seed pair
      if (wr_pos == 0 && data_req.wdata != {ramtest_pkg::data_seed_hi,
                                            ramtest_pkg::data_seed_lo}) begin
        report_mismatch("first write data", {ramtest_pkg::data_seed_hi,
                        ramtest_pkg::data_seed_lo}, data_req.wdata);
      end
      if (data_req.addr != seq_addr[wr_pos]) begin
        report_mismatch("write addr", 64'(seq_addr[wr_pos]), 64'(data_req.addr));
      end
      if (data_req.wdata != seq_data[wr_pos]) begin
        report_mismatch("write data", seq_data[wr_pos], data_req.wdata);
      end
      wr_pos++;
    end else begin
      if (data_req.addr != seq_addr[rd_pos]) begin
        report_mismatch("read addr", 64'(seq_addr[rd_pos]), 64'(data_req.addr));
      end
      if (data_rsp.rdata != seq_data[rd_pos]) begin
        report_mismatch("read data", seq_data[rd_pos], data_rsp.rdata);
      end
      rd_pos++;
    end
    done_count++;
  endtask

  // observe the buses half a cycle after each edge
  always @(negedge clk) begin
    if (rst) begin
      if (rst_prev && flags != '0) begin
        report_mismatch("flags during reset", 64'd0, 64'(flags));
      end
      wr_pos = 0;
      rd_pos = 0;
      ir_pos = 0;
      done_count = 0;
      since_rst = -1;
      data_seen = 1'b0;
      inst_seen = 1'b0;
    end else begin
      since_rst++;
      if (since_rst == 0 && flags != '0) begin
        report_mismatch("flags after reset", 64'd0, 64'(flags));
      end
      if (data_req.stb && !data_seen) begin
        data_seen = 1'b1;
        if (since_rst != data_first_stb) begin
          report_mismatch("first data stb cycle", 64'(data_first_stb), 64'(since_rst));
        end
      end
      if (inst_req.stb && !inst_seen) begin
        inst_seen = 1'b1;
        if (since_rst != inst_first_stb) begin
          report_mismatch("first inst stb cycle", 64'(inst_first_stb), 64'(since_rst));
        end
      end
      if (test_ended && ((data_req.stb && !data_stb_prev) ||
                         (inst_req.stb && !inst_stb_prev))) begin
        report_fault("a strobe rose after test_ended");
      end
      if (test_ended != (done_count >= end_count)) begin
        report_mismatch("test_ended", 64'(done_count >= end_count), 64'(test_ended));
      end
      // instruction side first, so it is compared with earlier writes only
      if (inst_rsp.ack) begin
        check_inst_ack();
      end
      if (data_rsp.ack) begin
        check_data_ack();
      end
    end
    rst_prev = rst;
    data_stb_prev = data_req.stb;
    inst_stb_prev = inst_req.stb;
  end

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycle_limit > 0 && cycles >= cycle_limit) begin
      $display("timeout after %0d cycles, the data port never finished its rows", cycles);
      $display("transactions checked %0d, errors %0d", checked, errors);
      $display("Something failed");
      $finish;
    end
  end

  task automatic run_row(input int r);
    test_name = row_name[r];
    @(posedge clk);
    rst <= 1'b1;
    repeat (row_rst[r]) @(posedge clk);
    rst <= 1'b0;
    while (done_count < row_trans[r]) begin
      @(posedge clk);
    end
    repeat (2) @(posedge clk);
    if (test_ended != row_end[r]) begin
      report_mismatch("test_ended at row end", 64'(row_end[r]), 64'(test_ended));
    end
    if (test_error) begin
      report_mismatch("test_error", 64'd0, 64'(test_error));
    end
  endtask

  initial begin
    int total;
    total = 0;
    rst = 1'b1;
    build_sequence();
    for (int r = 0; r < num_rows; r++) begin
      total += row_trans[r];
    end
    // worst case per transaction is one data period plus the ack wait
    cycle_limit = total * (17 + ram_latency + 2) + 200;
    for (int r = 0; r < num_rows; r++) begin
      run_row(r);
    end
    // idle tail where no strobe may rise
    repeat (60) @(posedge clk);
    if (test_error) begin
      report_mismatch("test_error at end", 64'd0, 64'(test_error));
    end
    $display("transactions checked %0d, errors %0d", checked, errors);
    if (errors == 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

endmodule

// ==== verif/ramtest_properties.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// port protocol assertions, bound to every ram_test_gen instance
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module ramtest_properties (
  input logic                  clk,
  input logic                  rst,
  input ramtest_pkg::mem_req_t inst_req,
  input ramtest_pkg::mem_req_t data_req,
  input ramtest_pkg::mem_rsp_t inst_rsp,
  input ramtest_pkg::mem_rsp_t data_rsp,
  input logic                  test_ended
);

  // a strobe waits for its ack with the request held
  inst_hold: assert property (@(posedge clk) disable iff (rst)
    inst_req.stb && !inst_rsp.ack |=> inst_req.stb && $stable(inst_req.addr))
    else $error("instruction request changed before its ack");

  data_hold: assert property (@(posedge clk) disable iff (rst)
    data_req.stb && !data_rsp.ack |=> data_req.stb && $stable(data_req.addr)
      && $stable(data_req.we) && $stable(data_req.wdata))
    else $error("data request changed before its ack");

  inst_ack_stb: assert property (@(posedge clk) disable iff (rst)
    inst_rsp.ack |-> inst_req.stb)
    else $error("instruction ack without a strobe");

  data_ack_stb: assert property (@(posedge clk) disable iff (rst)
    data_rsp.ack |-> data_req.stb)
    else $error("data ack without a strobe");

  ended_sticky: assert property (@(posedge clk) disable iff (rst)
    test_ended |=> test_ended)
    else $error("test_ended fell outside reset");

  // once ended, an idle port stays idle
  inst_no_rise: assert property (@(posedge clk) disable iff (rst)
    test_ended && !inst_req.stb |=> !inst_req.stb)
    else $error("instruction strobe rose after test_ended");

  data_no_rise: assert property (@(posedge clk) disable iff (rst)
    test_ended && !data_req.stb |=> !data_req.stb)
    else $error("data strobe rose after test_ended");

endmodule

bind ram_test_gen ramtest_properties u_props (
  .clk       (clk),
  .rst       (rst),
  .inst_req  (inst_req),
  .data_req  (data_req),
  .inst_rsp  (inst_rsp),
  .data_rsp  (data_rsp),
  .test_ended(test_ended)
);

// ==== verilog/ramtest_top.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// addr_bits 8 to 22, len_bits at least 2, ram_latency 1 to 8
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module ramtest_top #(
  parameter int addr_bits = 12,
  parameter int len_bits = 10,
  parameter int ram_latency = 2
) (
  input  logic                  clk,
  input  logic                  rst,
  output logic                  test_ended,
  output logic                  test_error,
  output ramtest_pkg::mem_req_t inst_req,
  output ramtest_pkg::mem_rsp_t inst_rsp,
  output ramtest_pkg::mem_req_t data_req,
  output ramtest_pkg::mem_rsp_t data_rsp
);

  ram_test_gen #(
    .addr_bits(addr_bits),
    .len_bits (len_bits)
  ) u_gen (
    .clk       (clk),
    .rst       (rst),
    .inst_rsp  (inst_rsp),
    .data_rsp  (data_rsp),
    .inst_req  (inst_req),
    .data_req  (data_req),
    .test_ended(test_ended),
    .test_error(test_error)
  );

  // instruction side on port a, data side on port b
  dual_port_ram #(
    .addr_bits  (addr_bits),
    .ram_latency(ram_latency)
  ) u_ram (
    .clk       (clk),
    .rst       (rst),
    .port_a_req(inst_req),
    .port_b_req(data_req),
    .port_a_rsp(inst_rsp),
    .port_b_rsp(data_rsp)
  );

endmodule

// ==== verilog/dual_port_ram.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// ram_latency must be 1 or more, port a never writes
// same-address access on both ports in one cycle is not handled
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module dual_port_ram #(
  parameter int addr_bits = 12,
  parameter int ram_latency = 2
) (
  input  logic                  clk,
  input  logic                  rst,
  input  ramtest_pkg::mem_req_t port_a_req,
  input  ramtest_pkg::mem_req_t port_b_req,
  output ramtest_pkg::mem_rsp_t port_a_rsp,
  output ramtest_pkg::mem_rsp_t port_b_rsp
);

  localparam int words = 2 ** addr_bits;
  localparam int lat_bits = $clog2(ram_latency + 1);
  localparam logic [lat_bits-1:0] lat_last = lat_bits'(ram_latency - 1);

  ramtest_pkg::data_t mem [words];

  ramtest_pkg::mem_req_t [1:0] req;
  ramtest_pkg::mem_rsp_t [1:0] rsp;

  assign req = {port_b_req, port_a_req};

  for (genvar p = 0; p < 2; p++) begin : g_port
    logic [lat_bits-1:0]  lat_cnt;
    logic                 served;
    logic                 ack_q;
    logic                 fire;
    logic [addr_bits-1:0] word;
    ramtest_pkg::data_t   rdata_q;

    assign word = req[p].addr[addr_bits-1:0];
    assign fire = req[p].stb && !served && (lat_cnt == lat_last);

    // served holds off a second ack until the strobe drops
    always_ff @(posedge clk) begin
      if (rst) begin
        lat_cnt <= '0;
        served  <= 1'b0;
        ack_q   <= 1'b0;
      end else begin
        ack_q <= fire;
        if (!req[p].stb) begin
          served  <= 1'b0;
          lat_cnt <= '0;
        end else if (fire) begin
          served  <= 1'b1;
          lat_cnt <= '0;
        end else if (!served) begin
          lat_cnt <= lat_cnt + 1'b1;
        end
      end
    end

    always_ff @(posedge clk) begin
      if (fire) begin
        rdata_q <= mem[word];
      end
    end

    assign rsp[p] = '{ack: ack_q, rdata: rdata_q};
  end

  // data side commits its write in the ack cycle
  always_ff @(posedge clk) begin
    if (port_b_req.stb && port_b_req.we && rsp[1].ack) begin
      mem[port_b_req.addr[addr_bits-1:0]] <= port_b_req.wdata;
    end
  end

  assign port_a_rsp = rsp[0];
  assign port_b_rsp = rsp[1];

endmodule

// ==== verilog/ram_test_gen.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// writer must stay ahead of both readers, which holds for ram latency <= 8
// len_bits must be at least 2 and test_error is sticky until reset
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module ram_test_gen #(
  parameter int addr_bits = 12,
  parameter int len_bits = 10
) (
  input  logic                  clk,
  input  logic                  rst,
  input  ramtest_pkg::mem_rsp_t inst_rsp,
  input  ramtest_pkg::mem_rsp_t data_rsp,
  output ramtest_pkg::mem_req_t inst_req,
  output ramtest_pkg::mem_req_t data_req,
  output logic                  test_ended,
  output logic                  test_error
);

  // port 0 is the instruction side, port 1 the data side
  localparam int inst_port = 0;
  localparam int data_port = 1;

  logic [1:0] port_wait;
  logic [1:0] port_ack;
  logic [1:0] port_done;

  logic [len_bits-1:0] data_count;
  logic                data_we;
  logic                inst_bad;
  logic                data_bad;

  logic [addr_bits-1:0]              ir_addr;
  logic [addr_bits-1:0]              dw_addr;
  logic [addr_bits-1:0]              dr_addr;
  logic [ramtest_pkg::data_bits-1:0] ir_data;
  logic [ramtest_pkg::data_bits-1:0] dw_data;
  logic [ramtest_pkg::data_bits-1:0] dr_data;

  assign port_ack = {data_rsp.ack, inst_rsp.ack};

  // per-port timer and strobe FSM
  for (genvar p = 0; p < 2; p++) begin : g_port
    localparam logic [4:0] period = (p == inst_port) ? 5'd31 : 5'd17;
    localparam logic [4:0] phase = (p == inst_port) ? 5'd19 : 5'd7;

    ramtest_pkg::port_state_t state;
    logic [4:0]               timer;

    always_ff @(posedge clk) begin
      if (rst) begin
        state <= ramtest_pkg::PORT_COUNT;
        timer <= '0;
      end else begin
        case (state)
          ramtest_pkg::PORT_COUNT: begin
            // no new strobes once the test has ended
            if (!test_ended) begin
              timer <= (timer == period - 5'd1) ? 5'd0 : timer + 5'd1;
              if (timer == phase) begin
                state <= ramtest_pkg::PORT_WAIT;
              end
            end
          end
          default: begin
            if (port_ack[p]) begin
              state <= ramtest_pkg::PORT_COUNT;
            end
          end
        endcase
      end
    end

    assign port_wait[p] = (state == ramtest_pkg::PORT_WAIT);
  end

  assign port_done = port_wait & port_ack;

  // three writes, then one read
  assign data_we = ~&data_count[1:0];
  assign test_ended = &data_count;

  always_ff @(posedge clk) begin
    if (rst) begin
      data_count <= '0;
    end else if (port_done[data_port]) begin
      data_count <= data_count + 1'b1;
    end
  end

  assign inst_bad = port_done[inst_port] && (inst_rsp.rdata != ir_data);
  assign data_bad = port_done[data_port] && !data_we && (data_rsp.rdata != dr_data);

  always_ff @(posedge clk) begin
    if (rst) begin
      test_error <= 1'b0;
    end else if (inst_bad || data_bad) begin
      test_error <= 1'b1;
    end
  end

  addr_data_gen #(
    .addr_bits(addr_bits)
  ) gen_inst_rd (
    .clk (clk),
    .rst (rst),
    .next(port_done[inst_port]),
    .addr(ir_addr),
    .data(ir_data)
  );

  addr_data_gen #(
    .addr_bits(addr_bits)
  ) gen_data_wr (
    .clk (clk),
    .rst (rst),
    .next(port_done[data_port] & data_we),
    .addr(dw_addr),
    .data(dw_data)
  );

  addr_data_gen #(
    .addr_bits(addr_bits)
  ) gen_data_rd (
    .clk (clk),
    .rst (rst),
    .next(port_done[data_port] & ~data_we),
    .addr(dr_addr),
    .data(dr_data)
  );

  // generators only step on ack, so the buses hold while a strobe is out
  always_comb begin
    inst_req.stb   = port_wait[inst_port];
    inst_req.we    = 1'b0;
    inst_req.addr  = ramtest_pkg::bus_addr_t'(ir_addr);
    inst_req.wdata = '0;

    data_req.stb   = port_wait[data_port];
    data_req.we    = port_wait[data_port] & data_we;
    data_req.addr  = ramtest_pkg::bus_addr_t'(data_we ? dw_addr : dr_addr);
    data_req.wdata = dw_data;
  end

endmodule

// ==== verilog/addr_data_gen.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// addr_bits must be 8 to 22, so the address repeats only after
// 2**addr_bits - 1 steps and never reaches zero
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module addr_data_gen #(
  parameter int addr_bits = 12
) (
  input  logic                           clk,
  input  logic                           rst,
  input  logic                           next,
  output logic [addr_bits-1:0]           addr,
  output logic [ramtest_pkg::data_bits-1:0] data
);

  localparam logic [addr_bits-1:0] addr_taps = addr_bits'(ramtest_pkg::lfsr_taps(addr_bits));
  localparam logic [addr_bits-1:0] addr_init = addr_bits'(ramtest_pkg::addr_seed);

  logic [addr_bits-1:0] addr_q;
  logic [31:0]          data_hi;
  logic [31:0]          data_lo;

  // one step of a 32-bit data half
  function automatic logic [31:0] step32(input logic [31:0] v);
    if (v[0]) begin
      return (v >> 1) ^ ramtest_pkg::data_poly;
    end
    return v >> 1;
  endfunction

  always_ff @(posedge clk) begin
    if (rst) begin
      addr_q  <= addr_init;
      data_hi <= ramtest_pkg::data_seed_hi;
      data_lo <= ramtest_pkg::data_seed_lo;
    end else if (next) begin
      if (addr_q[0]) begin
        addr_q <= (addr_q >> 1) ^ addr_taps;
      end else begin
        addr_q <= addr_q >> 1;
      end
      data_hi <= step32(data_hi);
      data_lo <= step32(data_lo);
    end
  end

  assign addr = addr_q;
  assign data = {data_hi, data_lo};

endmodule

// ==== verilog/ramtest_pkg.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// shared widths, seeds and port types of the RAM test subsystem
// lfsr_taps only covers address widths 8 to 22 and returns 0 outside
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

package ramtest_pkg;

  localparam int bus_addr_bits = 26;
  localparam int data_bits = 64;

  typedef logic [bus_addr_bits-1:0] bus_addr_t;
  typedef logic [data_bits-1:0] data_t;

  // generator reset values, the address seed is cut to the LFSR width
  localparam logic [21:0] addr_seed = 22'h0337DB;
  localparam logic [31:0] data_seed_hi = 32'h7F4D514F;
  localparam logic [31:0] data_seed_lo = 32'h75377599;

  // right-shifting Galois feedback for both data halves
  localparam logic [31:0] data_poly = 32'hD0000001;

  typedef enum logic {
    PORT_COUNT,
    PORT_WAIT
  } port_state_t;

  typedef struct packed {
    logic      stb;
    logic      we;
    bus_addr_t addr;
    data_t     wdata;
  } mem_req_t;

  typedef struct packed {
    logic  ack;
    data_t rdata;
  } mem_rsp_t;

  // maximal-length masks for a right-shifting Galois LFSR
  function automatic logic [21:0] lfsr_taps(input int width);
    case (width)
      8:       return 22'h0000B8;
      9:       return 22'h000110;
      10:      return 22'h000240;
      11:      return 22'h000500;
      12:      return 22'h000829;
      13:      return 22'h00100D;
      14:      return 22'h002015;
      15:      return 22'h006000;
      16:      return 22'h00D008;
      17:      return 22'h012000;
      18:      return 22'h020400;
      19:      return 22'h040023;
      20:      return 22'h090000;
      21:      return 22'h140000;
      22:      return 22'h300000;
      default: return 22'h000000;
    endcase
  endfunction

endpackage
